// ==== Makefile ====
# Verilator build and run of the SPI slave memory testbench

TOP := spiMemoryTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): sim.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== hdl/dataMemory.sv ====
// 128-byte data memory with address latch, read is combinational from the latched address
`timescale 1ns/1ps

module dataMemory
    import spiMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     addrWe,     // capture addrIn at end of command byte
    input  logic     memWe,      // write pulse at end of data byte
    input  spiAddr_t addrIn,
    input  spiByte_t writeData,
    output spiByte_t readData
);

    spiByte_t mem [memDepth];
    spiAddr_t addrReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            addrReg <= '0;
        end else if (addrWe) begin
            addrReg <= addrIn;
        end
    end

    // storage itself keeps its contents over reset
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[addrReg] <= writeData;
        end
    end

    assign readData = mem[addrReg];   // valid the cycle after addrWe

endmodule

// ==== hdl/inputConditioner.sv ====
// synchronizes and deglitches one async SPI pin, giving a clean level plus edge pulses
`timescale 1ns/1ps

module inputConditioner
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic pin,   // raw asynchronous pin
    output logic cond,  // filtered level
    output logic rise,  // one cycle, same cycle cond goes high
    output logic fall   // one cycle, same cycle cond goes low
);

    logic [syncStages-1:0] syncReg;
    logic                  synced;
    // counts consecutive samples that differ from cond
    logic [$clog2(filterCycles+1)-1:0] matchCount;

    assign synced = syncReg[syncStages-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            syncReg    <= '0;
            matchCount <= '0;
            cond       <= 1'b0;
            rise       <= 1'b0;
            fall       <= 1'b0;
        end else begin
            syncReg <= {syncReg[syncStages-2:0], pin};
            rise    <= 1'b0;
            fall    <= 1'b0;
            if (synced == cond) begin
                matchCount <= '0;   // glitch or no change, start over
            end else if (matchCount == filterCycles - 1) begin
                // enough equal samples in a row, accept the new level
                cond       <= synced;
                rise       <= synced;
                fall       <= !synced;
                matchCount <= '0;
            end else begin
                matchCount <= matchCount + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/shiftRegister.sv ====
// 8-bit SPI shift register, samples mosi on sclk rise and drives miso on sclk fall or load
`timescale 1ns/1ps

module shiftRegister
    import spiMemPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     sclkRise,    // conditioned sclk rising edge pulse
    input  logic     sclkFall,    // conditioned sclk falling edge pulse
    input  logic     serialIn,    // conditioned mosi level
    input  logic     loadEn,      // parallel load from memory
    input  spiByte_t parallelIn,
    output spiByte_t parallelOut,
    output logic     serialOut
);

    // shift path, msb first so new bits enter at the lsb
    always_ff @(posedge clk) begin
        if (rst) begin
            parallelOut <= '0;
        end else if (loadEn) begin
            parallelOut <= parallelIn;
        end else if (sclkRise) begin
            parallelOut <= {parallelOut[byteWidth-2:0], serialIn};
        end
    end

    // miso output register
    // mode 0: the master samples on rise, so the slave only changes miso on fall
    always_ff @(posedge clk) begin
        if (rst) begin
            serialOut <= 1'b0;
        end else if (loadEn) begin
            serialOut <= parallelIn[byteWidth-1];   // msb ready before first data rise
        end else if (sclkFall) begin
            serialOut <= parallelOut[byteWidth-1];
        end
    end

endmodule

// ==== hdl/spiMemPkg.sv ====
// shared widths, types and conditioner timing for the SPI slave memory, imported by every block
package spiMemPkg;

    // command byte is a 7-bit address followed by the read/write bit
    localparam int addrWidth = 7;
    localparam int byteWidth = 8;
    localparam int memDepth  = 128;

    // input conditioner timing, pin to cond latency is syncStages + filterCycles
    localparam int syncStages   = 2;
    localparam int filterCycles = 2;

    // a memory address
    typedef logic [addrWidth-1:0] spiAddr_t;

    // a data or command byte as it sits in the shift register
    typedef logic [byteWidth-1:0] spiByte_t;

    // bit position within a byte, wraps 7 -> 0 at the end of each byte
    typedef logic [2:0] bitCount_t;

    // transaction sequencer states
    typedef enum logic [2:0] {
        sGetAddr,   // shifting in the command byte
        sRead1,     // memory read data is loaded into the shift register
        sRead2,     // data byte goes out on miso
        sWrite1,    // one cycle before collecting the data byte
        sWrite2,    // shifting in the data byte
        sDone       // byte handled, waiting for cs to go high
    } fsmState_t;

endpackage

// ==== hdl/spiMemory.sv ====
// top level of the SPI slave memory, pins come in raw and the miso pad sits outside
`timescale 1ns/1ps

module spiMemory
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic cs,
    input  logic mosi,
    output logic miso,
    output logic misoEn    // pad output enable
);

    // pin order in the conditioner arrays: 0 sclk, 1 cs, 2 mosi
    logic [2:0] rawPins;
    logic [2:0] cond;
    logic [2:0] rise;
    logic [2:0] fall;

    logic     addrWe;
    logic     loadEn;
    logic     memWe;
    spiByte_t parallelOut;
    spiByte_t readData;

    assign rawPins = {mosi, cs, sclk};

    for (genvar i = 0; i < 3; i++) begin : gCond
        inputConditioner conditioner (
            .clk  (clk),
            .rst  (rst),
            .pin  (rawPins[i]),
            .cond (cond[i]),
            .rise (rise[i]),
            .fall (fall[i])
        );
    end

    spiSlaveFsm fsm (
        .clk      (clk),
        .rst      (rst),
        .sclkRise (rise[0]),
        .csLevel  (cond[1]),
        .csRise   (rise[1]),
        .rwBit    (parallelOut[0]),
        .addrWe   (addrWe),
        .loadEn   (loadEn),
        .memWe    (memWe),
        .misoEn   (misoEn)
    );

    shiftRegister shifter (
        .clk         (clk),
        .rst         (rst),
        .sclkRise    (rise[0]),
        .sclkFall    (fall[0]),
        .serialIn    (cond[2]),
        .loadEn      (loadEn),
        .parallelIn  (readData),
        .parallelOut (parallelOut),
        .serialOut   (miso)
    );

    // address is the top 7 bits of the command byte
    dataMemory memory (
        .clk       (clk),
        .rst       (rst),
        .addrWe    (addrWe),
        .memWe     (memWe),
        .addrIn    (parallelOut[byteWidth-1:1]),
        .writeData (parallelOut),
        .readData  (readData)
    );

endmodule

// ==== hdl/spiSlaveFsm.sv ====
// sequences one SPI transaction, command byte capture then a read or a write of one data byte
`timescale 1ns/1ps

module spiSlaveFsm
    import spiMemPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sclkRise,   // conditioned sclk rising edge pulse
    input  logic csLevel,    // conditioned chip select, high means idle
    input  logic csRise,     // end or abort of the transaction
    input  logic rwBit,      // shift register lsb, 1 means read
    output logic addrWe,
    output logic loadEn,
    output logic memWe,
    output logic misoEn
);

    fsmState_t state;
    bitCount_t bitCount;
    logic      byteDone;
    logic      misoActive;   // read data phase reached

    // the eighth rise of a byte, counter about to wrap
    assign byteDone = sclkRise && (bitCount == 3'd7);

    // drop the enable in the same cycle cs is seen high
    assign misoEn = misoActive && !csLevel;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sGetAddr;
            bitCount   <= '0;
            addrWe     <= 1'b0;
            loadEn     <= 1'b0;
            memWe      <= 1'b0;
            misoActive <= 1'b0;
        end else if (csLevel || csRise) begin
            // idle or aborted, wait for the next cs fall
            state      <= sGetAddr;
            bitCount   <= '0;
            addrWe     <= 1'b0;
            loadEn     <= 1'b0;
            memWe      <= 1'b0;
            misoActive <= 1'b0;
        end else begin
            addrWe <= 1'b0;   // pulse outputs
            loadEn <= 1'b0;
            memWe  <= 1'b0;

            if (sclkRise) begin
                bitCount <= bitCount + 3'd1;
            end

            case (state)
                sGetAddr: begin
                    if (addrWe) begin
                        // command byte complete in the shift register, lsb is r/w
                        state  <= rwBit ? sRead1 : sWrite1;
                        loadEn <= rwBit;   // memory read data valid in sRead1
                    end else if (byteDone) begin
                        addrWe <= 1'b1;
                    end
                end
                sRead1: begin
                    state      <= sRead2;
                    misoActive <= 1'b1;
                end
                sRead2: begin
                    if (byteDone) begin
                        state <= sDone;   // misoEn held until cs goes high
                    end
                end
                sWrite1: begin
                    state <= sWrite2;
                end
                sWrite2: begin
                    if (byteDone) begin
                        memWe <= 1'b1;    // shift register holds the full data byte next cycle
                        state <= sDone;
                    end
                end
                sDone: begin
                    state <= sDone;       // extra bits ignored, no bursts
                end
                default: begin
                    state <= sGetAddr;
                end
            endcase
        end
    end

endmodule

// ==== sim.f ====
hdl/spiMemPkg.sv
hdl/inputConditioner.sv
hdl/shiftRegister.sv
hdl/dataMemory.sv
hdl/spiSlaveFsm.sv
hdl/spiMemory.sv
testbench/spiMemory_assertions.sv
testbench/spiMemoryTb.sv

// ==== testbench/spiMemoryTb.sv ====
// testbench for the SPI slave memory, drives the pins as SPI master and checks reads against a model
`timescale 1ns/1ps

module spiMemoryTb
    import spiMemPkg::*;
();

    localparam int sclkHalf = 8;   // clk cycles per sclk level

    logic clk;
    logic rst;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic misoEn;

    integer   seed = 32'hf7b2_44ea;
    spiByte_t modelMem [memDepth];   // mirror of the DUT memory
    logic     modelValid [memDepth];
    spiAddr_t readAddrQ [$];         // reads waiting for comparison
    spiByte_t readDataQ [$];
    int       readsChecked = 0;

    spiMemory uut (
        .clk    (clk),
        .rst    (rst),
        .sclk   (sclk),
        .cs     (cs),
        .mosi   (mosi),
        .miso   (miso),
        .misoEn (misoEn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    // cs is high and conditioned, the miso pad must stay off
    task automatic idleCheck(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            assert (misoEn == 1'b0)
                else reportFailure($sformatf("ERR %0t: misoEn high while cs is idle", $time));
        end
    endtask

    // mode 0, mosi changes with the sclk fall, miso is taken when sclk goes high
    // misoEn must match expectEn at every sample point
    task automatic transferBits(input spiByte_t txByte, input int nBits, input logic expectEn,
                                output spiByte_t rxByte);
        rxByte = '0;
        for (int i = byteWidth - 1; i >= byteWidth - nBits; i--) begin
            sclk <= 1'b0;
            mosi <= txByte[i];
            waitCycles(sclkHalf);
            rxByte[i] = miso;
            assert (misoEn === expectEn)
                else reportFailure($sformatf("ERR %0t: misoEn %b expected %b",
                                             $time, misoEn, expectEn));
            sclk <= 1'b1;
            waitCycles(sclkHalf);
        end
        sclk <= 1'b0;
    endtask

    task automatic startTransaction();
        cs <= 1'b0;
        waitCycles(sclkHalf);   // cs conditioned low before the first sclk rise
    endtask

    task automatic endTransaction();
        cs <= 1'b1;
        waitCycles(sclkHalf);
        idleCheck(sclkHalf);
    endtask

    task automatic writeByte(input spiAddr_t addr, input spiByte_t data);
        spiByte_t unused;
        startTransaction();
        transferBits({addr, 1'b0}, byteWidth, 1'b0, unused);
        transferBits(data, byteWidth, 1'b0, unused);
        endTransaction();
        modelMem[addr]   = data;
        modelValid[addr] = 1'b1;
    endtask

    // cs goes high after half the data byte, memory must keep its old value
    task automatic abortWrite(input spiAddr_t addr, input spiByte_t data);
        spiByte_t unused;
        startTransaction();
        transferBits({addr, 1'b0}, byteWidth, 1'b0, unused);
        transferBits(data, 4, 1'b0, unused);
        endTransaction();
    endtask

    task automatic readByte(input spiAddr_t addr);
        spiByte_t unused;
        spiByte_t rx;
        startTransaction();
        transferBits({addr, 1'b1}, byteWidth, 1'b0, unused);
        transferBits(8'h00, byteWidth, 1'b1, rx);   // pad enabled for the data byte
        endTransaction();
        readAddrQ.push_back(addr);
        readDataQ.push_back(rx);
    endtask

    // model byte for an address, written is low if it was never stored
    function automatic spiByte_t expectedRead(input spiAddr_t addr, output logic written);
        written = modelValid[addr];
        return modelMem[addr];
    endfunction

    initial begin : compareReads
        spiAddr_t addr;
        spiByte_t actual;
        spiByte_t expected;
        logic     written;
        forever begin
            @(posedge clk);
            while (readAddrQ.size() > 0) begin
                addr     = readAddrQ.pop_front();
                actual   = readDataQ.pop_front();
                expected = expectedRead(addr, written);
                if (written) begin
                    assert (actual === expected)
                        else reportFailure($sformatf(
                            "ERR %0t: read addr 0x%02h expected 0x%02h got 0x%02h",
                            $time, addr, expected, actual));
                    readsChecked++;
                end
            end
        end
    end

    initial begin : mainSequence
        spiAddr_t    addr;
        spiByte_t    data;
        logic [31:0] randWord;
        int          drainWait;
        rst  = 1'b1;
        sclk = 1'b0;
        cs   = 1'b1;
        mosi = 1'b0;
        for (int i = 0; i < memDepth; i++) begin
            modelMem[i]   = '0;
            modelValid[i] = 1'b0;
        end
        waitCycles(2);
        rst <= 1'b0;
        idleCheck(2 * sclkHalf);

        writeByte(7'h15, 8'ha5);   // write then read back
        readByte(7'h15);
        writeByte(7'h2a, 8'h3c);   // overwrite keeps the second byte
        writeByte(7'h2a, 8'hc3);
        readByte(7'h2a);
        abortWrite(7'h2a, 8'h5f);
        readByte(7'h2a);

        // reset in the middle of a read command byte
        startTransaction();
        transferBits({7'h40, 1'b1}, 4, 1'b0, data);
        rst <= 1'b1;
        waitCycles(2);
        rst <= 1'b0;
        cs  <= 1'b1;
        idleCheck(2 * sclkHalf);
        writeByte(7'h40, 8'h96);
        readByte(7'h40);

        for (int n = 0; n < 200; n++) begin
            randWord = $random(seed);
            addr     = randWord[addrWidth-1:0];
            data     = randWord[15:8];
            if (randWord[20]) begin
                readByte(addr);
            end else begin
                writeByte(addr, data);
            end
        end

        drainWait = 0;
        while (readAddrQ.size() > 0 && drainWait < 10) begin
            @(posedge clk);
            drainWait++;
        end
        if (readAddrQ.size() > 0) begin
            reportFailure("timeout while waiting for the read comparisons to finish");
        end else if (readsChecked < 4) begin
            reportFailure("fewer reads were compared than the directed tests issued");
        end else begin
            $display("%0d reads compared", readsChecked);
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== testbench/spiMemory_assertions.sv ====
// concurrent protocol checks on the transaction FSM, attached to every spiSlaveFsm by bind
`timescale 1ns/1ps

module fsmProtocolChecks
    import spiMemPkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      csLevel,
    input logic      addrWe,
    input logic      loadEn,
    input logic      memWe,
    input logic      misoEn,
    input fsmState_t state
);

    // a memory write and a read load never overlap
    noWriteDuringLoad: assert property (
        @(posedge clk) disable iff (rst) !(memWe && loadEn)
    ) else $error("memWe and loadEn high in the same cycle");

    writePulse: assert property (
        @(posedge clk) disable iff (rst) memWe |=> !memWe
    ) else $error("memWe lasted more than one cycle");

    addrPulse: assert property (
        @(posedge clk) disable iff (rst) addrWe |=> !addrWe
    ) else $error("addrWe lasted more than one cycle");

    // pad only on in the read data phase, and off while the slave is deselected
    misoOnlyInReadPhase: assert property (
        @(posedge clk) disable iff (rst)
            misoEn |-> !csLevel && (state == sRead2 || state == sDone)
    ) else $error("misoEn high outside the read data phase or while cs is high");

    resetClearsOutputs: assert property (
        @(posedge clk) rst |=> !(addrWe || loadEn || memWe || misoEn)
    ) else $error("control outputs not cleared after reset");

endmodule

bind spiSlaveFsm fsmProtocolChecks protocolChecks (
    .clk     (clk),
    .rst     (rst),
    .csLevel (csLevel),
    .addrWe  (addrWe),
    .loadEn  (loadEn),
    .memWe   (memWe),
    .misoEn  (misoEn),
    .state   (state)
);
